// File: files.f
hw/mdpt_pkg.sv
hw/mdpt_index_hash.sv
hw/mdpt_array.sv
hw/mdpt_tag_match.sv
hw/mdpt.sv
hw/mdpt_wrapper.sv
dv/mdpt_assertions.sv
dv/mdpt_tb.sv

// File: dv/mdpt_tb.sv
// MDPT testbench with LFSR stimulus and a flat model; expected blocks trail the drive edge by five
`timescale 1ns/1ps

module mdpt_tb;

    // ------------------------------------------------------------
    // Run length
    localparam int RESET_CYCLES    = 3;
    localparam int DIRECTED_CYCLES = 30;
    localparam int RANDOM_CYCLES   = 200;
    localparam int CYCLE_LIMIT     = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 20;

    logic                                 CLK;
    logic                                 nRST;
    logic                                 next_valid_REQ;
    logic [31:0]                          next_full_PC_REQ;
    logic [mdpt_pkg::ASID_WIDTH-1:0]      next_ASID_REQ;
    logic                                 next_dep_update0_valid;
    logic [31:0]                          next_dep_update0_start_full_PC;
    logic [mdpt_pkg::ASID_WIDTH-1:0]      next_dep_update0_ASID;
    logic [mdpt_pkg::MDPT_INFO_WIDTH-1:0] next_dep_update0_mdp_info;
    mdpt_pkg::mdpt_block_t                last_mdp_info_by_instr_RESP;

    // Reference table
    logic                                model_valid [mdpt_pkg::MDPT_SETS];
    logic [mdpt_pkg::MDPT_TAG_WIDTH-1:0] model_tag   [mdpt_pkg::MDPT_SETS];
    mdpt_pkg::mdpt_block_t               model_block [mdpt_pkg::MDPT_SETS];

    // Expected block per drive edge with the newest in entry 0
    mdpt_pkg::mdpt_block_t [4:0] exp_pipe = '0;
    logic [31:0]                 lfsr_state = 32'h10c2c542;
    int unsigned                 error_count = 0;
    int unsigned                 cycle_count = 0;

    mdpt_wrapper u_dut (.*);

    bind mdpt mdpt_assertions u_mdpt_assertions (
        .CLK                    (CLK),
        .nRST                   (nRST),
        .lookup                 (lookup),
        .lookup_q               (lookup_q),
        .update                 (update),
        .mdp_info_by_instr_RESP (mdp_info_by_instr_RESP)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // ------------------------------------------------------------
    // Stimulus helpers

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        end
        return val;
    endfunction

    // Narrow PC space so random traffic hits and evicts often
    function automatic logic [31:0] random_pc();
        logic [31:0] upper_sel;
        logic [31:0] set_sel;
        logic [31:0] slot;
        upper_sel = rand_bits(2);
        set_sel   = rand_bits(3);
        slot      = rand_bits(3);
        return {19'h0, upper_sel[1:0], 3'b000, set_sel[2:0], slot[2:0], 2'b00};
    endfunction

    // Bit 6 moves only the tag while bit 0 also moves the set
    function automatic logic [8:0] random_asid();
        logic [31:0] sel;
        sel = rand_bits(2);
        return {2'b00, sel[1], 5'b00000, sel[0]};
    endfunction

    // Set index and tag as the package hash rules define them
    function automatic logic [5:0] set_of(input logic [31:0] pc, input logic [8:0] asid);
        return pc[10:5] ^ asid[5:0];
    endfunction

    function automatic logic [9:0] tag_of(input logic [31:0] pc, input logic [8:0] asid);
        return pc[20:11] ^ pc[30:21] ^ {pc[31], asid};
    endfunction

    function automatic mdpt_pkg::mdpt_block_t lookup_expected(input logic [31:0] pc,
                                                               input logic [8:0]  asid);
        logic [5:0] idx;
        idx = set_of(pc, asid);
        if (model_valid[idx] && model_tag[idx] == tag_of(pc, asid)) begin
            return model_block[idx];
        end
        return '0;
    endfunction

    // Tag mismatch takes over the set with one live slot
    task automatic apply_update(input logic [31:0] pc, input logic [8:0] asid,
                                input logic [7:0] info);
        logic [5:0] idx;
        logic [9:0] tag;
        idx = set_of(pc, asid);
        tag = tag_of(pc, asid);
        if (!(model_valid[idx] && model_tag[idx] == tag)) begin
            model_valid[idx] = 1'b1;
            model_tag[idx]   = tag;
            model_block[idx] = '0;
        end
        model_block[idx][pc[4:2]] = info;
    endtask

    // One edge of stimulus; the request reads the model before this edge's update
    task automatic drive_cycle(input logic req_v, input logic [31:0] req_pc,
                               input logic [8:0] req_asid, input logic upd_v,
                               input logic [31:0] upd_pc, input logic [8:0] upd_asid,
                               input logic [7:0] upd_info);
        mdpt_pkg::mdpt_block_t exp_block;
        @(posedge CLK);
        next_valid_REQ                 <= req_v;
        next_full_PC_REQ               <= req_pc;
        next_ASID_REQ                  <= req_asid;
        next_dep_update0_valid         <= upd_v;
        next_dep_update0_start_full_PC <= upd_pc;
        next_dep_update0_ASID          <= upd_asid;
        next_dep_update0_mdp_info      <= upd_info;
        exp_block = req_v ? lookup_expected(req_pc, req_asid) : '0;
        if (upd_v) begin
            apply_update(upd_pc, upd_asid, upd_info);
        end
        exp_pipe <= {exp_pipe[3:0], exp_block};
    endtask

    task automatic request_block(input logic [31:0] pc, input logic [8:0] asid);
        drive_cycle(1'b1, pc, asid, 1'b0, '0, '0, '0);
    endtask

    task automatic update_slot(input logic [31:0] pc, input logic [8:0] asid,
                               input logic [7:0] info);
        drive_cycle(1'b0, '0, '0, 1'b1, pc, asid, info);
    endtask

    // Lookup only with the table left untouched
    task automatic random_request();
        logic [31:0] req_pc;
        logic [8:0]  req_asid;
        req_pc   = random_pc();
        req_asid = random_asid();
        request_block(req_pc, req_asid);
    endtask

    task automatic random_cycle();
        logic [31:0] req_pc;
        logic [8:0]  req_asid;
        logic [31:0] upd_sel;
        logic [31:0] upd_pc;
        logic [8:0]  upd_asid;
        logic [31:0] info;
        req_pc   = random_pc();
        req_asid = random_asid();
        upd_sel  = rand_bits(1);
        upd_pc   = random_pc();
        upd_asid = random_asid();
        info     = rand_bits(8);
        drive_cycle(1'b1, req_pc, req_asid, upd_sel[0], upd_pc, upd_asid, info[7:0]);
    endtask

    // ------------------------------------------------------------
    // Checking

    // Response three edges after the wrapper samples the request
    resp_matches_model: assert property (@(posedge CLK) disable iff (!nRST)
        last_mdp_info_by_instr_RESP == exp_pipe[4])
    else begin
        error_count++;
        $display("error: last_mdp_info_by_instr_RESP expected %h got %h",
                 $sampled(exp_pipe[4]), $sampled(last_mdp_info_by_instr_RESP));
    end

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Sequence
    initial begin
        logic [31:0] pc_a;
        logic [31:0] pc_b;
        logic [8:0]  asid_a;
        logic [8:0]  asid_c;
        pc_a   = 32'h0004_2a40;
        pc_b   = pc_a ^ 32'h0000_0800;
        asid_a = 9'h05a;
        asid_c = asid_a ^ 9'h040;
        foreach (model_valid[i]) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
            model_block[i] = '0;
        end
        nRST                           = 1'b0;
        next_valid_REQ                 = 1'b0;
        next_full_PC_REQ               = '0;
        next_ASID_REQ                  = '0;
        next_dep_update0_valid         = 1'b0;
        next_dep_update0_start_full_PC = '0;
        next_dep_update0_ASID          = '0;
        next_dep_update0_mdp_info      = '0;
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;

        // Empty table misses everywhere
        repeat (8) random_request();
        // Single slot then accumulate and overwrite
        update_slot(pc_a | 32'h0c, asid_a, 8'ha5);
        request_block(pc_a, asid_a);
        update_slot(pc_a, asid_a, 8'h11);
        update_slot(pc_a | 32'h14, asid_a, 8'h22);
        update_slot(pc_a | 32'h1c, asid_a, 8'h33);
        request_block(pc_a | 32'h04, asid_a);
        update_slot(pc_a | 32'h0c, asid_a, 8'h3c);
        request_block(pc_a, asid_a);
        // Other upper PC bits in the same set
        update_slot(pc_b | 32'h08, asid_a, 8'h5b);
        request_block(pc_a, asid_a);
        request_block(pc_b, asid_a);
        // Same PC with the ASID changed above the index bits
        update_slot(pc_a | 32'h18, asid_c, 8'h6e);
        request_block(pc_b, asid_a);
        request_block(pc_a, asid_c);
        // Same edge sees old data and the next edge the new word
        drive_cycle(1'b1, pc_a, asid_c, 1'b1, pc_a | 32'h18, asid_c, 8'h77);
        request_block(pc_a, asid_c);

        // Back to back requests with random updates
        repeat (RANDOM_CYCLES) random_cycle();
        repeat (6) drive_cycle(1'b0, '0, '0, 1'b0, '0, '0, '0);

        $display("checks done: model errors %0d, assertion errors %0d",
                 error_count, u_dut.u_mdpt.u_mdpt_assertions.fail_count);
        if (error_count == 0 && u_dut.u_mdpt.u_mdpt_assertions.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: dv/mdpt_assertions.sv
// Bound into the MDPT core; timing and X checks are off while nRST is low
`timescale 1ns/1ps

module mdpt_assertions (
    input logic                   CLK,
    input logic                   nRST,
    input mdpt_pkg::mdpt_lookup_t lookup,
    input mdpt_pkg::mdpt_lookup_t lookup_q,
    input mdpt_pkg::mdpt_update_t update,
    input mdpt_pkg::mdpt_block_t  mdp_info_by_instr_RESP
);

    // Failed assertion count
    int unsigned fail_count = 0;

    // ------------------------------------------------------------
    // Reset state

    // One edge into reset everything is cleared
    reset_clears_state: assert property (@(posedge CLK)
        !nRST |=> (!lookup.valid && !lookup_q.valid && !update.valid
                   && mdp_info_by_instr_RESP == '0))
    else begin
        fail_count++;
        $error("valid registers or response not cleared by reset");
    end

    // ------------------------------------------------------------
    // Pipeline timing

    // Hashed request reaches the match stage one edge later
    lookup_aligns: assert property (@(posedge CLK) disable iff (!nRST)
        lookup.valid |=> lookup_q.valid)
    else begin
        fail_count++;
        $error("delayed lookup did not follow a valid hashed request");
    end

    // No unknown bits leak out of the table
    resp_known: assert property (@(posedge CLK) disable iff (!nRST)
        !$isunknown(mdp_info_by_instr_RESP))
    else begin
        fail_count++;
        $error("core response has unknown bits out of reset");
    end

endmodule

// File: hw/mdpt_wrapper.sv
// Timing wrapper that flops every MDPT input and the response; requests return three edges later
`timescale 1ns/1ps

module mdpt_wrapper (
    input  logic                                 CLK,
    input  logic                                 nRST,

    // Request
    input  logic                                 next_valid_REQ,
    input  logic [31:0]                          next_full_PC_REQ,
    input  logic [mdpt_pkg::ASID_WIDTH-1:0]      next_ASID_REQ,

    // Response
    output mdpt_pkg::mdpt_block_t                last_mdp_info_by_instr_RESP,

    // Dependence update
    input  logic                                 next_dep_update0_valid,
    input  logic [31:0]                          next_dep_update0_start_full_PC,
    input  logic [mdpt_pkg::ASID_WIDTH-1:0]      next_dep_update0_ASID,
    input  logic [mdpt_pkg::MDPT_INFO_WIDTH-1:0] next_dep_update0_mdp_info
);

    // ------------------------------------------------------------
    // Core side signals

    // Request
    logic                                 valid_REQ;
    logic [31:0]                          full_PC_REQ;
    logic [mdpt_pkg::ASID_WIDTH-1:0]      ASID_REQ;

    // Response
    mdpt_pkg::mdpt_block_t                mdp_info_by_instr_RESP;

    // Dependence update
    logic                                 dep_update0_valid;
    logic [31:0]                          dep_update0_start_full_PC;
    logic [mdpt_pkg::ASID_WIDTH-1:0]      dep_update0_ASID;
    logic [mdpt_pkg::MDPT_INFO_WIDTH-1:0] dep_update0_mdp_info;

    // Names line up with the core ports
    mdpt u_mdpt (.*);

    // ------------------------------------------------------------
    // Boundary registers

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_REQ                   <= 1'b0;
            full_PC_REQ                 <= '0;
            ASID_REQ                    <= '0;
            last_mdp_info_by_instr_RESP <= '0;
            dep_update0_valid           <= 1'b0;
            dep_update0_start_full_PC   <= '0;
            dep_update0_ASID            <= '0;
            dep_update0_mdp_info        <= '0;
        end else begin
            // Request in
            valid_REQ                   <= next_valid_REQ;
            full_PC_REQ                 <= next_full_PC_REQ;
            ASID_REQ                    <= next_ASID_REQ;

            // Response out
            last_mdp_info_by_instr_RESP <= mdp_info_by_instr_RESP;

            // Update in
            dep_update0_valid           <= next_dep_update0_valid;
            dep_update0_start_full_PC   <= next_dep_update0_start_full_PC;
            dep_update0_ASID            <= next_dep_update0_ASID;
            dep_update0_mdp_info        <= next_dep_update0_mdp_info;
        end
    end

endmodule

// File: hw/mdpt.sv
// MDPT core with a two-cycle lookup path to the combinational response and a two-cycle update path
`timescale 1ns/1ps

module mdpt (
    input  logic                                 CLK,
    input  logic                                 nRST,

    // Request
    input  logic                                 valid_REQ,
    input  logic [31:0]                          full_PC_REQ,
    input  logic [mdpt_pkg::ASID_WIDTH-1:0]      ASID_REQ,

    // Response
    output mdpt_pkg::mdpt_block_t                mdp_info_by_instr_RESP,

    // Dependence update
    input  logic                                 dep_update0_valid,
    input  logic [31:0]                          dep_update0_start_full_PC,
    input  logic [mdpt_pkg::ASID_WIDTH-1:0]      dep_update0_ASID,
    input  logic [mdpt_pkg::MDPT_INFO_WIDTH-1:0] dep_update0_mdp_info
);

    // ------------------------------------------------------------
    // Internal stage signals

    mdpt_pkg::mdpt_lookup_t              lookup;
    mdpt_pkg::mdpt_lookup_t              lookup_q;
    mdpt_pkg::mdpt_update_t              update;
    logic [mdpt_pkg::MDPT_TAG_WIDTH-1:0] rd_tag;
    logic                                rd_hit_valid;
    mdpt_pkg::mdpt_block_t               rd_block;

    // ------------------------------------------------------------
    // Hash stages

    // Lookup copy, info unused
    mdpt_index_hash u_req_hash (
        .CLK     (CLK),
        .nRST    (nRST),
        .valid   (valid_REQ),
        .full_PC (full_PC_REQ),
        .ASID    (ASID_REQ),
        .info    ('0),
        .lookup  (lookup),
        .update  ()
    );

    // Update copy
    mdpt_index_hash u_upd_hash (
        .CLK     (CLK),
        .nRST    (nRST),
        .valid   (dep_update0_valid),
        .full_PC (dep_update0_start_full_PC),
        .ASID    (dep_update0_ASID),
        .info    (dep_update0_mdp_info),
        .lookup  (),
        .update  (update)
    );

    // ------------------------------------------------------------
    // Array and response

    mdpt_array u_array (
        .CLK          (CLK),
        .nRST         (nRST),
        .rd           (lookup),
        .wr           (update),
        .rd_tag       (rd_tag),
        .rd_hit_valid (rd_hit_valid),
        .rd_block     (rd_block)
    );

    // Lookup lined up with the array read register
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            lookup_q <= '0;
        end else begin
            lookup_q <= lookup;
        end
    end

    mdpt_tag_match u_tag_match (
        .lookup_q               (lookup_q),
        .rd_tag                 (rd_tag),
        .rd_hit_valid           (rd_hit_valid),
        .rd_block               (rd_block),
        .mdp_info_by_instr_RESP (mdp_info_by_instr_RESP)
    );

endmodule

// File: hw/mdpt_tag_match.sv
// Combinational hit check after the array read; a miss or an invalid lookup yields an all-zero block
`timescale 1ns/1ps

module mdpt_tag_match (
    input  mdpt_pkg::mdpt_lookup_t              lookup_q,
    input  logic [mdpt_pkg::MDPT_TAG_WIDTH-1:0] rd_tag,
    input  logic                                rd_hit_valid,
    input  mdpt_pkg::mdpt_block_t               rd_block,
    output mdpt_pkg::mdpt_block_t               mdp_info_by_instr_RESP
);

    // ------------------------------------------------------------
    // Hit detect

    logic tag_equal;
    logic hit;

    // Stored tag against the hashed request tag
    assign tag_equal = (rd_tag == lookup_q.tag);

    // Set must be live and the request real
    assign hit = lookup_q.valid && rd_hit_valid && tag_equal;

    // ------------------------------------------------------------
    // Response select

    // Entries on a hit
    // Zeros otherwise, never stale data
    always_comb begin
        if (hit) begin
            mdp_info_by_instr_RESP = rd_block;
        end else begin
            mdp_info_by_instr_RESP = '0;
        end
    end

endmodule

// File: hw/mdpt_array.sv
// Flop-based 64-set MDPT storage; a read and a write to one set on one edge return the old contents
`timescale 1ns/1ps

module mdpt_array (
    input  logic                                CLK,
    input  logic                                nRST,
    input  mdpt_pkg::mdpt_lookup_t              rd,
    input  mdpt_pkg::mdpt_update_t              wr,
    output logic [mdpt_pkg::MDPT_TAG_WIDTH-1:0] rd_tag,
    output logic                                rd_hit_valid,
    output mdpt_pkg::mdpt_block_t               rd_block
);

    // ------------------------------------------------------------
    // Storage

    // Per-set valid bits
    logic [mdpt_pkg::MDPT_SETS-1:0]      set_valid;
    logic [mdpt_pkg::MDPT_TAG_WIDTH-1:0] tag_mem   [mdpt_pkg::MDPT_SETS];
    mdpt_pkg::mdpt_block_t               block_mem [mdpt_pkg::MDPT_SETS];

    // Write side helpers
    logic                  wr_tag_hit;
    mdpt_pkg::mdpt_block_t wr_fresh_block;

    // Stored set already belongs to this tag
    assign wr_tag_hit = set_valid[wr.index] && (tag_mem[wr.index] == wr.tag);

    // Block image for a set being taken over
    // Only the addressed slot survives
    always_comb begin
        wr_fresh_block = '0;
        wr_fresh_block[wr.offset] = wr.info;
    end

    // ------------------------------------------------------------
    // Write port

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            set_valid <= '0;
        end else if (wr.valid) begin
            set_valid[wr.index] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (wr.valid) begin
            if (wr_tag_hit) begin
                // Same block, single slot overwrite
                block_mem[wr.index][wr.offset] <= wr.info;
            end else begin
                // New owner of the set
                tag_mem[wr.index]   <= wr.tag;
                block_mem[wr.index] <= wr_fresh_block;
            end
        end
    end

    // ------------------------------------------------------------
    // Read port

    // Valid bit of the read set, cleared on reset
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rd_hit_valid <= 1'b0;
        end else if (rd.valid) begin
            rd_hit_valid <= set_valid[rd.index];
        end
    end

    // Tag and entries held until the next valid read
    always_ff @(posedge CLK) begin
        if (rd.valid) begin
            rd_tag   <= tag_mem[rd.index];
            rd_block <= block_mem[rd.index];
        end
    end

endmodule

// File: hw/mdpt_index_hash.sv
// One-cycle registered PC/ASID hash; the caller decides whether the lookup or the update output is used
`timescale 1ns/1ps

module mdpt_index_hash (
    input  logic                                 CLK,
    input  logic                                 nRST,
    input  logic                                 valid,
    input  mdpt_pkg::mdpt_pc_u                   full_PC,
    input  logic [mdpt_pkg::ASID_WIDTH-1:0]      ASID,
    input  logic [mdpt_pkg::MDPT_INFO_WIDTH-1:0] info,
    output mdpt_pkg::mdpt_lookup_t               lookup,
    output mdpt_pkg::mdpt_update_t               update
);

    // ------------------------------------------------------------
    // Hash logic

    logic [mdpt_pkg::MDPT_INDEX_WIDTH-1:0] hash_index;
    logic [mdpt_pkg::MDPT_TAG_WIDTH-1:0]   hash_tag;

    // Set index folds in the low ASID bits
    assign hash_index = full_PC.fields.index ^ ASID[mdpt_pkg::MDPT_INDEX_WIDTH-1:0];

    // Tag is three 10-bit pieces XORed together
    // Top upper bit pads the 9-bit ASID
    assign hash_tag = full_PC.fields.upper[9:0]
                    ^ full_PC.fields.upper[19:10]
                    ^ {full_PC.fields.upper[20], ASID};

    // ------------------------------------------------------------
    // Output register

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            lookup <= '0;
            update <= '0;
        end else begin
            // Read side
            lookup.valid  <= valid;
            lookup.index  <= hash_index;
            lookup.tag    <= hash_tag;

            // Write side carries the slot and word too
            update.valid  <= valid;
            update.index  <= hash_index;
            update.tag    <= hash_tag;
            update.offset <= full_PC.fields.offset;
            update.info   <= info;
        end
    end

endmodule

// File: hw/mdpt_pkg.sv
// Fixed MDPT geometry of 64 direct mapped sets x 8 slots and 32-bit PCs, with no parameter overrides
package mdpt_pkg;

    // ------------------------------------------------------------
    // Table geometry

    // Direct mapped sets
    localparam int MDPT_SETS              = 64;
    localparam int MDPT_INDEX_WIDTH       = 6;
    // One slot per 4-byte instruction in a 32-byte block
    localparam int MDPT_ENTRIES_PER_BLOCK = 8;
    localparam int MDPT_OFFSET_WIDTH      = 3;
    // Prediction word
    localparam int MDPT_INFO_WIDTH        = 8;
    localparam int MDPT_TAG_WIDTH         = 10;
    localparam int ASID_WIDTH             = 9;
    // PC bits above the set index
    localparam int MDPT_PC_UPPER_WIDTH    = 21;

    // ------------------------------------------------------------
    // PC views

    // Field split of a fetch PC, MSB first
    typedef struct packed {
        logic [MDPT_PC_UPPER_WIDTH-1:0] upper;
        logic [MDPT_INDEX_WIDTH-1:0]    index;
        logic [MDPT_OFFSET_WIDTH-1:0]   offset;
        logic [1:0]                     byte_sel;
    } mdpt_pc_fields_t;

    // Same 32-bit word, raw or split
    typedef union packed {
        logic [31:0]     raw;
        mdpt_pc_fields_t fields;
    } mdpt_pc_u;

    // ------------------------------------------------------------
    // Stage structs

    // Hashed read request, 17 bits
    typedef struct packed {
        logic                        valid;
        logic [MDPT_INDEX_WIDTH-1:0] index;
        logic [MDPT_TAG_WIDTH-1:0]   tag;
    } mdpt_lookup_t;

    // Hashed slot write, 28 bits
    typedef struct packed {
        logic                         valid;
        logic [MDPT_INDEX_WIDTH-1:0]  index;
        logic [MDPT_TAG_WIDTH-1:0]    tag;
        logic [MDPT_OFFSET_WIDTH-1:0] offset;
        logic [MDPT_INFO_WIDTH-1:0]   info;
    } mdpt_update_t;

    // Slot 0 sits in the low byte
    typedef logic [MDPT_ENTRIES_PER_BLOCK-1:0][MDPT_INFO_WIDTH-1:0] mdpt_block_t;

endpackage
